// File: all.f
+incdir+.
miner_pix_pkg.sv
miner_map_pkg.sv
map_ram.sv
background_draw.sv
sprite_draw.sv
round_timer.sv
view_ctrl.sv
game_view.sv
game_view_chk.sv
game_view_tb.sv

// File: background_draw.sv
// raster scan of the whole screen, sky above the ground line and dirt below
`timescale 1ns/1ps
`include "miner_consts.svh"

module background_draw
	import miner_pix_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       bg_start,
	output pix_x_t     bg_x,
	output pix_y_t     bg_y,
	output pix_color_t bg_color,
	output logic       bg_valid,
	output logic       bg_done
);

	logic active;
	logic row_end;

	assign row_end = (bg_x == pix_x_t'(`MINER_SCREEN_W - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active  <= 1'b0;
			bg_x    <= '0;
			bg_y    <= '0;
			bg_done <= 1'b0;
		end else begin
			bg_done <= 1'b0;
			if (bg_start) begin
				active <= 1'b1;
				bg_x   <= '0;
				bg_y   <= '0;
			end else if (active) begin
				if (row_end) begin
					bg_x <= '0;
					bg_y <= bg_y + pix_y_t'(1);
					// last row finished
					if (bg_y == pix_y_t'(`MINER_SCREEN_H - 1)) begin
						active  <= 1'b0;
						bg_done <= 1'b1;
					end
				end else begin
					bg_x <= bg_x + pix_x_t'(1);
				end
			end
		end
	end

	assign bg_valid = active;
	assign bg_color = (bg_y < pix_y_t'(`MINER_GROUND_Y)) ? `MINER_SKY_COLOR : `MINER_DIRT_COLOR;

endmodule

// File: game_view.sv
// top of the play field view: map, drawers, round timer, FSM and the pixel bus register
`timescale 1ns/1ps

module game_view
	import miner_pix_pkg::*, miner_map_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        go,
	input  logic [9:0]  score,
	input  logic        map_we,
	input  map_addr_t   map_waddr,
	input  logic [31:0] map_wdata,
	output pix_x_t      x_out,
	output pix_y_t      y_out,
	output pix_color_t  color_out,
	output logic        write_en,
	output logic [2:0]  level,
	output logic [7:0]  time_remaining,
	output logic        game_over
);

	logic       bg_start, bg_done, bg_valid;
	logic       sprite_start, sprite_done, spr_valid;
	logic       timer_load, timer_run, time_up;
	pix_x_t     bg_x, spr_x;
	pix_y_t     bg_y, spr_y;
	pix_color_t bg_color, spr_color;
	map_addr_t  map_raddr;
	map_entry_u map_rdata;

	map_ram u_map (.clk, .resetn, .map_we, .map_waddr, .map_wdata, .map_raddr, .map_rdata);

	background_draw u_bg (.clk, .resetn, .bg_start, .bg_x, .bg_y, .bg_color, .bg_valid, .bg_done);

	sprite_draw u_spr (.clk, .resetn, .sprite_start, .map_rdata,
		.spr_x, .spr_y, .spr_color, .spr_valid, .sprite_done);

	round_timer u_timer (.clk, .resetn, .timer_load, .timer_run, .time_remaining, .time_up);

	view_ctrl u_ctrl (.clk, .resetn, .go, .score, .time_up, .bg_done, .sprite_done, .map_rdata,
		.bg_start, .sprite_start, .map_raddr, .timer_load, .timer_run, .level, .game_over);

	// only one drawer runs at a time
	always_ff @(posedge clk) begin
		if (!resetn) begin
			write_en <= 1'b0;
		end else begin
			write_en <= bg_valid | spr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (bg_valid) begin
			x_out     <= bg_x;
			y_out     <= bg_y;
			color_out <= bg_color;
		end else begin
			x_out     <= spr_x;
			y_out     <= spr_y;
			color_out <= spr_color;
		end
	end

endmodule

// File: game_view_chk.sv
// bound assertions on the play field top, attached to every game_view instance by bind
`timescale 1ns/1ps
`include "miner_consts.svh"

module game_view_chk
	import miner_pix_pkg::*;
(
	input logic       clk,
	input logic       resetn,
	input logic       write_en,
	input pix_x_t     x_out,
	input pix_y_t     y_out,
	input logic [2:0] level,
	input logic       game_over
);

	a_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		write_en |-> (x_out < pix_x_t'(`MINER_SCREEN_W)) && (y_out < pix_y_t'(`MINER_SCREEN_H)))
		else $error("pixel write off screen");

	// drawing stays stopped once the round is lost
	a_quiet_over: assert property (@(posedge clk) disable iff (!resetn)
		game_over |-> !$rose(write_en))
		else $error("pixel write started after game over");

	a_level_up_only: assert property (@(posedge clk) disable iff (!resetn)
		level >= $past(level))
		else $error("level went down");

endmodule

bind game_view game_view_chk u_chk (.clk, .resetn, .write_en, .x_out, .y_out, .level, .game_over);

// File: game_view_input.txt
// map words x[31:23] y[18:11] kind[3:2] visible[1], four per line, entries 0 to 15
// then go delay in cycles, two score steps, object writes per frame, final level (hex)
0A032006 1E03C00A 3204B00E 6402D004
9606400A 0500500E 19019002 4B050008
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
5
4B 96
180
2

// File: game_view_tb.sv
// testbench for the play field view, loads the map and runs frames, level ups and game over
`timescale 1ns/1ps
`include "miner_consts.svh"

module game_view_tb;

	localparam int FRAME_PIX = `MINER_SCREEN_W * `MINER_SCREEN_H;
	localparam int TICK = `MINER_TICK_CYCLES;

	logic        clk, resetn, go, map_we;
	logic [9:0]  score;
	logic [3:0]  map_waddr;
	logic [31:0] map_wdata;
	logic [8:0]  x_out;
	logic [7:0]  y_out;
	logic [11:0] color_out;
	logic        write_en, game_over;
	logic [2:0]  level;
	logic [7:0]  time_remaining;

	// 0..15 map, 16 go delay, 17..18 score steps, 19 object writes, 20 final level
	logic [31:0] stim [0:20];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_err0 = 0;
	int obj_expect = 0;

	game_view UUT (.clk, .resetn, .go, .score, .map_we, .map_waddr, .map_wdata,
		.x_out, .y_out, .color_out, .write_en, .level, .time_remaining, .game_over);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// three frames and one full round fit well inside 400k cycles
	initial begin
		#16_000_000;
		$display("timeout: simulation did not reach its end");
		$display("Verification failed");
		$finish;
	end

	task automatic compare(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_err0) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_err0);
		end
	endtask

	function automatic int kind_size(input logic [1:0] k);
		case (k)
			2'd1: return `MINER_GOLD_SIZE;
			2'd2: return `MINER_STONE_SIZE;
			2'd3: return `MINER_DIAMOND_SIZE;
			default: return 0;
		endcase
	endfunction

	function automatic int kind_color(input logic [1:0] k);
		case (k)
			2'd1: return int'(`MINER_GOLD_COLOR);
			2'd2: return int'(`MINER_STONE_COLOR);
			2'd3: return int'(`MINER_DIAMOND_COLOR);
			default: return 0;
		endcase
	endfunction

	// colour of the visible object covering a pixel, 0 where there is none
	function automatic int object_color(input int x, input int y);
		int ox, oy, sz;
		for (int i = 0; i < `MINER_MAP_DEPTH; i++) begin
			ox = int'(stim[i][31:23]);
			oy = int'(stim[i][18:11]);
			sz = kind_size(stim[i][3:2]);
			if (stim[i][1] && x >= ox && x < ox + sz && y >= oy && y < oy + sz) begin
				return kind_color(stim[i][3:2]);
			end
		end
		return 0;
	endfunction

	function automatic int object_writes();
		int sum = 0;
		int sz;
		for (int i = 0; i < `MINER_MAP_DEPTH; i++) begin
			sz = kind_size(stim[i][3:2]);
			if (stim[i][1]) begin
				sum += sz * sz;
			end
		end
		return sum;
	endfunction

	// raster background, then the visible objects, until the round timer runs
	task automatic check_frame();
		int n = 0;
		int cyc = 0;
		int exp_col;
		while (!write_en && cyc < 100) begin
			@(negedge clk);
			cyc++;
		end
		if (!write_en) begin
			report_problem("no pixel write after the frame start");
			return;
		end
		cyc = 0;
		while (!UUT.timer_run && cyc < FRAME_PIX + 2000) begin
			if (write_en && n < FRAME_PIX) begin
				exp_col = (n / `MINER_SCREEN_W < `MINER_GROUND_Y) ?
					int'(`MINER_SKY_COLOR) : int'(`MINER_DIRT_COLOR);
				compare("background x", int'(x_out), n % `MINER_SCREEN_W);
				compare("background y", int'(y_out), n / `MINER_SCREEN_W);
				compare("background colour", int'(color_out), exp_col);
			end else if (write_en) begin
				compare("object colour", int'(color_out),
					object_color(int'(x_out), int'(y_out)));
			end
			n += int'(write_en);
			@(negedge clk);
			cyc++;
		end
		if (!UUT.timer_run) begin
			report_problem("frame did not end with the round timer running");
		end
		compare("background writes", (n < FRAME_PIX) ? n : FRAME_PIX, FRAME_PIX);
		compare("object writes", n - FRAME_PIX, obj_expect);
	endtask

	// every change of the countdown must be a single step down
	task automatic watch_timer(input int stop_at, input int limit);
		int prev;
		int cyc = 0;
		prev = int'(time_remaining);
		while (int'(time_remaining) != stop_at && !game_over && cyc < limit) begin
			@(negedge clk);
			cyc++;
			if (int'(time_remaining) != prev) begin
				compare("timer step", int'(time_remaining), prev - 1);
				prev = int'(time_remaining);
			end
		end
		if (cyc >= limit) begin
			report_problem("round timer did not count down in time");
		end
	endtask

	initial begin
		int cyc;
		resetn = 1'b0;
		go = 1'b0;
		score = '0;
		map_we = 1'b0;
		map_waddr = '0;
		map_wdata = '0;
		$readmemh("game_view_input.txt", stim);
		obj_expect = object_writes();
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);

		start_test();
		compare("write_en after reset", int'(write_en), 0);
		compare("game_over after reset", int'(game_over), 0);
		compare("level after reset", int'(level), 0);
		compare("time after reset", int'(time_remaining), `MINER_ROUND_SECONDS);
		finish_test("reset state");

		start_test();
		if (stim[19] == 0) begin
			report_problem("input data file missing or empty");
		end
		compare("object writes in input file", int'(stim[19]), obj_expect);
		for (int i = 0; i < `MINER_MAP_DEPTH; i++) begin
			@(posedge clk);
			map_we <= 1'b1;
			map_waddr <= 4'(i);
			map_wdata <= stim[i];
		end
		@(posedge clk);
		map_we <= 1'b0;
		repeat (int'(stim[16])) @(posedge clk);
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		@(negedge clk);
		check_frame();
		finish_test("first frame");

		start_test();
		watch_timer(`MINER_ROUND_SECONDS - 2, 3 * TICK);
		finish_test("timer countdown");

		for (int s = 0; s < 2; s++) begin
			start_test();
			@(posedge clk);
			score <= 10'(stim[17 + s]);
			@(negedge clk);
			cyc = 0;
			while (int'(level) != s + 1 && cyc < 100) begin
				@(negedge clk);
				cyc++;
			end
			compare("level after goal", int'(level), s + 1);
			check_frame();
			compare("time after level up", int'(time_remaining), `MINER_ROUND_SECONDS);
			finish_test("level up");
		end

		// score stays below the next goal, so the round runs out
		start_test();
		watch_timer(0, (`MINER_ROUND_SECONDS + 1) * TICK);
		cyc = 0;
		while (!game_over && cyc < 10) begin
			@(negedge clk);
			cyc++;
		end
		if (!game_over) begin
			report_problem("game_over did not rise when the time ran out");
		end
		compare("time at game over", int'(time_remaining), 0);
		compare("final level", int'(level), int'(stim[20]));
		for (cyc = 0; cyc < 2 * TICK; cyc++) begin
			if (write_en) begin
				compare("write_en after game over", int'(write_en), 0);
			end
			@(negedge clk);
		end
		finish_test("game over");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: map_ram.sv
// object map memory, written through the external strobe port, read by the view FSM
`timescale 1ns/1ps
`include "miner_consts.svh"

module map_ram
	import miner_map_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        map_we,
	input  map_addr_t   map_waddr,
	input  logic [31:0] map_wdata,
	input  map_addr_t   map_raddr,
	output map_entry_u  map_rdata
);

	logic [31:0] mem [`MINER_MAP_DEPTH];

	// reset clears every entry, so nothing is visible until loaded
	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < `MINER_MAP_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (map_we) begin
			mem[map_waddr] <= map_wdata;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		map_rdata.raw <= mem[map_raddr];
	end

endmodule

// File: miner_consts.svh
// screen, sprite, map, timer and goal constants shared by the play field RTL
`ifndef MINER_CONSTS_SVH
`define MINER_CONSTS_SVH

// screen geometry
`define MINER_SCREEN_W 320
`define MINER_SCREEN_H 240
`define MINER_GROUND_Y 80

`define MINER_SKY_COLOR 12'h6cf
`define MINER_DIRT_COLOR 12'h852

// sprite edge lengths in pixels
`define MINER_GOLD_SIZE 8
`define MINER_STONE_SIZE 12
`define MINER_DIAMOND_SIZE 4

`define MINER_GOLD_COLOR 12'hfd2
`define MINER_STONE_COLOR 12'h888
`define MINER_DIAMOND_COLOR 12'h2ef

`define MINER_MAP_DEPTH 16
`define MINER_TICK_CYCLES 1000
`define MINER_ROUND_SECONDS 30
`define MINER_GOAL_STEP 75

`endif

// File: miner_map_pkg.sv
// object map types, the raw 32-bit map word and its decoded field view
package miner_map_pkg;

	typedef enum logic [1:0] {
		OBJ_NONE    = 2'd0,
		OBJ_GOLD    = 2'd1,
		OBJ_STONE   = 2'd2,
		OBJ_DIAMOND = 2'd3
	} obj_kind_t;

	// field layout of one map word, msb first
	typedef struct packed {
		logic [8:0] x;
		logic [3:0] rsvd_hi;
		logic [7:0] y;
		logic [6:0] rsvd_mid;
		obj_kind_t  kind;
		logic       visible;
		logic       rsvd_lo;
	} map_fields_t;

	// stored and written as raw, read back as fields
	typedef union packed {
		logic [31:0] raw;
		map_fields_t f;
	} map_entry_u;

	typedef logic [3:0] map_addr_t;

endpackage

// File: miner_pix_pkg.sv
// pixel coordinate and colour types for every block that drives the pixel bus
package miner_pix_pkg;

	// column 0..319
	typedef logic [8:0] pix_x_t;

	// row 0..239
	typedef logic [7:0] pix_y_t;

	// 4 bits each of red, green, blue
	typedef logic [11:0] pix_color_t;

endpackage

// File: round_timer.sv
// round countdown in seconds, with a clock prescaler and a time-up level
`timescale 1ns/1ps
`include "miner_consts.svh"

module round_timer (
	input  logic       clk,
	input  logic       resetn,
	input  logic       timer_load,
	input  logic       timer_run,
	output logic [7:0] time_remaining,
	output logic       time_up
);

	localparam int PRESC_W = $clog2(`MINER_TICK_CYCLES);

	logic [PRESC_W-1:0] presc;
	logic               tick;

	assign tick = (presc == PRESC_W'(`MINER_TICK_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!resetn || timer_load) begin
			presc          <= '0;
			time_remaining <= 8'(`MINER_ROUND_SECONDS);
		end else if (timer_run && !time_up) begin
			if (tick) begin
				presc          <= '0;
				time_remaining <= time_remaining - 8'd1;
			end else begin
				presc <= presc + PRESC_W'(1);
			end
		end
	end

	// holds at zero until the next load
	assign time_up = (time_remaining == 8'd0);

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module game_view_tb -f all.f -o game_view_sim &&
	./obj_dir/game_view_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

// File: sprite_draw.sv
// draws one map object as a filled square, size and colour chosen by the object kind
`timescale 1ns/1ps
`include "miner_consts.svh"

module sprite_draw
	import miner_pix_pkg::*, miner_map_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       sprite_start,
	input  map_entry_u map_rdata,
	output pix_x_t     spr_x,
	output pix_y_t     spr_y,
	output pix_color_t spr_color,
	output logic       spr_valid,
	output logic       sprite_done
);

	pix_x_t    org_x;
	pix_y_t    org_y;
	obj_kind_t kind;
	logic      active;
	logic [3:0] off_x;
	logic [3:0] off_y;
	logic [3:0] side;
	logic      col_end;

	// entry is on map_rdata in the start cycle
	always_ff @(posedge clk) begin
		if (sprite_start) begin
			org_x <= map_rdata.f.x;
			org_y <= map_rdata.f.y;
			kind  <= map_rdata.f.kind;
		end
	end

	always_comb begin
		case (kind)
			OBJ_GOLD: begin
				side      = 4'(`MINER_GOLD_SIZE);
				spr_color = `MINER_GOLD_COLOR;
			end
			OBJ_STONE: begin
				side      = 4'(`MINER_STONE_SIZE);
				spr_color = `MINER_STONE_COLOR;
			end
			OBJ_DIAMOND: begin
				side      = 4'(`MINER_DIAMOND_SIZE);
				spr_color = `MINER_DIAMOND_COLOR;
			end
			default: begin
				// no object, a single transparent cycle
				side      = 4'd1;
				spr_color = '0;
			end
		endcase
	end

	assign col_end = (off_x == side - 4'd1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active      <= 1'b0;
			off_x       <= '0;
			off_y       <= '0;
			sprite_done <= 1'b0;
		end else begin
			sprite_done <= 1'b0;
			if (sprite_start) begin
				active <= 1'b1;
				off_x  <= '0;
				off_y  <= '0;
			end else if (active) begin
				if (col_end) begin
					off_x <= '0;
					off_y <= off_y + 4'd1;
					if (off_y == side - 4'd1) begin
						active      <= 1'b0;
						sprite_done <= 1'b1;
					end
				end else begin
					off_x <= off_x + 4'd1;
				end
			end
		end
	end

	assign spr_x = org_x + pix_x_t'(off_x);
	assign spr_y = org_y + pix_y_t'(off_y);

	// colour 0 is transparent
	assign spr_valid = active && (spr_color != '0);

endmodule

// File: view_ctrl.sv
// frame sequencing FSM: background, then each visible object, then the timed round
`timescale 1ns/1ps
`include "miner_consts.svh"

module view_ctrl
	import miner_map_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       go,
	input  logic [9:0] score,
	input  logic       time_up,
	input  logic       bg_done,
	input  logic       sprite_done,
	input  map_entry_u map_rdata,
	output logic       bg_start,
	output logic       sprite_start,
	output map_addr_t  map_raddr,
	output logic       timer_load,
	output logic       timer_run,
	output logic [2:0] level,
	output logic       game_over
);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_BG    = 3'd1;
	localparam logic [2:0] S_FETCH = 3'd2;
	localparam logic [2:0] S_CHECK = 3'd3;
	localparam logic [2:0] S_DRAW  = 3'd4;
	localparam logic [2:0] S_PLAY  = 3'd5;
	localparam logic [2:0] S_OVER  = 3'd6;

	logic [2:0] state;
	map_addr_t  obj_idx;
	logic [9:0] goal;
	logic       last_obj;
	logic       obj_next;

	// goal grows by one step per level
	assign goal = 10'(`MINER_GOAL_STEP) * (10'(level) + 10'd1);

	assign last_obj  = (obj_idx == map_addr_t'(`MINER_MAP_DEPTH - 1));
	assign map_raddr = obj_idx;

	// current entry finished, either skipped or drawn
	assign obj_next = ((state == S_CHECK) && !map_rdata.f.visible) ||
		((state == S_DRAW) && sprite_done);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state        <= S_IDLE;
			obj_idx      <= '0;
			bg_start     <= 1'b0;
			sprite_start <= 1'b0;
			timer_load   <= 1'b0;
			timer_run    <= 1'b0;
			level        <= '0;
			game_over    <= 1'b0;
		end else begin
			bg_start     <= 1'b0;
			sprite_start <= 1'b0;
			timer_load   <= 1'b0;

			case (state)
				S_IDLE: begin
					if (go) begin
						bg_start   <= 1'b1;
						timer_load <= 1'b1;
						state      <= S_BG;
					end
				end
				S_BG: begin
					if (bg_done) begin
						obj_idx <= '0;
						state   <= S_FETCH;
					end
				end
				// address goes out here, data is back in S_CHECK
				S_FETCH: state <= S_CHECK;
				S_CHECK: begin
					if (map_rdata.f.visible) begin
						sprite_start <= 1'b1;
						state        <= S_DRAW;
					end
				end
				S_DRAW: ;
				S_PLAY: begin
					if (time_up) begin
						timer_run <= 1'b0;
						game_over <= 1'b1;
						state     <= S_OVER;
					end else if (score >= goal) begin
						// next level, fresh timer and a full redraw
						level      <= level + 3'd1;
						timer_load <= 1'b1;
						timer_run  <= 1'b0;
						bg_start   <= 1'b1;
						state      <= S_BG;
					end
				end
				S_OVER: ;
				default: state <= S_IDLE;
			endcase

			if (obj_next) begin
				if (last_obj) begin
					timer_run <= 1'b1;
					state     <= S_PLAY;
				end else begin
					obj_idx <= obj_idx + map_addr_t'(1);
					state   <= S_FETCH;
				end
			end
		end
	end

endmodule
